/* rtl/cdc_fifo_pkg.sv */
package cdc_fifo_pkg;

  // ==============================
  // FIFO geometry
  // ==============================
  localparam int DATA_WIDTH   = 8;
  localparam int FIFO_DEPTH   = 16;
  localparam int ADDR_WIDTH   = 4;   // Log2 of the depth.
  localparam int AFULL_LEVEL  = 12;  // Write-side level, at or above.
  localparam int AEMPTY_LEVEL = 2;   // Read-side level, at or below.

  // ==============================
  // APB register map
  // ==============================
  localparam int APB_ADDR_WIDTH = 4;
  localparam int APB_DATA_WIDTH = 32;

  localparam logic [APB_ADDR_WIDTH-1:0] REG_DATA   = 4'h0;  // Write pushes a word.
  localparam logic [APB_ADDR_WIDTH-1:0] REG_STATUS = 4'h4;  // Read only.

  // Status word layout.
  localparam int STATUS_FULL_BIT  = 0;
  localparam int STATUS_AFULL_BIT = 1;
  localparam int STATUS_LEVEL_LSB = 8;  // Level in bits 8 to 12.

endpackage

/* rtl/fifo_ports_if.sv */
`timescale 1ns/100ps

// Write side of the FIFO, wr_clk domain.
interface fifo_wr_if
  import cdc_fifo_pkg::*;
();

  logic                  push;
  logic [DATA_WIDTH-1:0] data;
  logic                  full;
  logic                  afull;
  logic [ADDR_WIDTH:0]   level;  // Up to FIFO_DEPTH.

  modport producer (
    output push, data,
    input  full, afull, level
  );

  modport buffer (
    input  push, data,
    output full, afull, level
  );

endinterface

// Read side of the FIFO, rd_clk domain.
interface fifo_rd_if
  import cdc_fifo_pkg::*;
();

  logic                  pop;
  logic [DATA_WIDTH-1:0] data;   // Valid one cycle after pop.
  logic                  empty;
  logic                  aempty;

  modport consumer (
    output pop,
    input  data, empty, aempty
  );

  modport buffer (
    input  pop,
    output data, empty, aempty
  );

endinterface

/* rtl/dualport_ram.sv */
`timescale 1ns/100ps

module dualport_ram
  import cdc_fifo_pkg::*;
(
  input  logic                  wr_clk,
  input  logic                  we,
  input  logic [ADDR_WIDTH-1:0] waddr,
  input  logic [DATA_WIDTH-1:0] wdata,
  input  logic                  rd_clk,
  input  logic                  re,
  input  logic [ADDR_WIDTH-1:0] raddr,
  output logic [DATA_WIDTH-1:0] rdata
);

  logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];

  always_ff @(posedge wr_clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Registered read port.
  always_ff @(posedge rd_clk) begin
    if (re) begin
      rdata <= mem[raddr];
    end
  end

endmodule

/* rtl/async_fifo.sv */
`timescale 1ns/100ps

module async_fifo
  import cdc_fifo_pkg::*;
(
  input  logic      wr_clk,
  input  logic      wr_rst_n,
  input  logic      rd_clk,
  input  logic      rd_rst_n,
  fifo_wr_if.buffer wr,
  fifo_rd_if.buffer rd
);

  // Write domain.
  logic              wr_en_ok;
  logic [ADDR_WIDTH:0] wr_bin;
  logic [ADDR_WIDTH:0] wr_bin_nxt;
  logic [ADDR_WIDTH:0] wr_gray;
  logic [ADDR_WIDTH:0] rd_gray_wsync1;
  logic [ADDR_WIDTH:0] rd_gray_wsync2;
  logic [ADDR_WIDTH:0] rd_bin_wsync;
  logic [ADDR_WIDTH:0] wr_level_nxt;

  // Read domain.
  logic              rd_en_ok;
  logic [ADDR_WIDTH:0] rd_bin;
  logic [ADDR_WIDTH:0] rd_bin_nxt;
  logic [ADDR_WIDTH:0] rd_gray;
  logic [ADDR_WIDTH:0] wr_gray_rsync1;
  logic [ADDR_WIDTH:0] wr_gray_rsync2;
  logic [ADDR_WIDTH:0] wr_bin_rsync;
  logic [ADDR_WIDTH:0] rd_level_nxt;

  function automatic logic [ADDR_WIDTH:0] gray2bin(input logic [ADDR_WIDTH:0] g);
    logic [ADDR_WIDTH:0] b;
    b[ADDR_WIDTH] = g[ADDR_WIDTH];
    for (int i = ADDR_WIDTH - 1; i >= 0; i--) begin
      b[i] = b[i+1] ^ g[i];
    end
    return b;
  endfunction

  dualport_ram i_ram (
    .wr_clk (wr_clk),
    .we     (wr_en_ok),
    .waddr  (wr_bin[ADDR_WIDTH-1:0]),
    .wdata  (wr.data),
    .rd_clk (rd_clk),
    .re     (rd_en_ok),
    .raddr  (rd_bin[ADDR_WIDTH-1:0]),
    .rdata  (rd.data)
  );

  // ==============================
  // Write side
  // ==============================
  assign wr_en_ok     = wr.push & ~wr.full;
  assign wr_bin_nxt   = wr_bin + {{ADDR_WIDTH{1'b0}}, wr_en_ok};
  assign rd_bin_wsync = gray2bin(rd_gray_wsync2);
  assign wr_level_nxt = wr_bin_nxt - rd_bin_wsync;  // Pessimistic by sync delay.

  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_bin         <= '0;
      wr_gray        <= '0;
      rd_gray_wsync1 <= '0;
      rd_gray_wsync2 <= '0;
      wr.level       <= '0;
      wr.full        <= 1'b0;
      wr.afull       <= 1'b0;
    end else begin
      wr_bin         <= wr_bin_nxt;
      wr_gray        <= (wr_bin_nxt >> 1) ^ wr_bin_nxt;
      rd_gray_wsync1 <= rd_gray;
      rd_gray_wsync2 <= rd_gray_wsync1;
      wr.level       <= wr_level_nxt;
      wr.full        <= (wr_level_nxt == (ADDR_WIDTH+1)'(FIFO_DEPTH));
      wr.afull       <= (wr_level_nxt >= (ADDR_WIDTH+1)'(AFULL_LEVEL));
    end
  end

  // ==============================
  // Read side
  // ==============================
  assign rd_en_ok     = rd.pop & ~rd.empty;
  assign rd_bin_nxt   = rd_bin + {{ADDR_WIDTH{1'b0}}, rd_en_ok};
  assign wr_bin_rsync = gray2bin(wr_gray_rsync2);
  assign rd_level_nxt = wr_bin_rsync - rd_bin_nxt;

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_bin         <= '0;
      rd_gray        <= '0;
      wr_gray_rsync1 <= '0;
      wr_gray_rsync2 <= '0;
      rd.empty       <= 1'b1;
      rd.aempty      <= 1'b1;
    end else begin
      rd_bin         <= rd_bin_nxt;
      rd_gray        <= (rd_bin_nxt >> 1) ^ rd_bin_nxt;
      wr_gray_rsync1 <= wr_gray;
      wr_gray_rsync2 <= wr_gray_rsync1;
      rd.empty       <= (rd_level_nxt == '0);
      rd.aempty      <= (rd_level_nxt <= (ADDR_WIDTH+1)'(AEMPTY_LEVEL));
    end
  end

endmodule

/* rtl/apb_fifo_writer.sv */
`timescale 1ns/100ps

module apb_fifo_writer
  import cdc_fifo_pkg::*;
(
  input  logic                      wr_clk,
  input  logic                      wr_rst_n,
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [APB_ADDR_WIDTH-1:0] paddr,
  input  logic [APB_DATA_WIDTH-1:0] pwdata,
  output logic [APB_DATA_WIDTH-1:0] prdata,
  output logic                      pready,
  output logic                      pslverr,
  fifo_wr_if.producer               wr
);

  logic                      setup_done;  // Previous cycle was a setup phase.
  logic                      access;
  logic                      data_wr;
  logic                      status_rd;
  logic [APB_DATA_WIDTH-1:0] status;

  // ==============================
  // APB phase tracking
  // ==============================
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      setup_done <= 1'b0;
    end else begin
      setup_done <= psel & ~penable;
    end
  end

  // Access phase only counts after a proper setup phase.
  assign access    = psel & penable & setup_done;
  assign data_wr   = access & pwrite & (paddr == REG_DATA);
  assign status_rd = access & ~pwrite & (paddr == REG_STATUS);

  // Push only when there is room, otherwise the word is dropped.
  assign wr.push = data_wr & ~wr.full;
  assign wr.data = pwdata[DATA_WIDTH-1:0];

  always_comb begin
    status                                         = '0;
    status[STATUS_FULL_BIT]                        = wr.full;
    status[STATUS_AFULL_BIT]                       = wr.afull;
    status[STATUS_LEVEL_LSB +: ADDR_WIDTH+1]       = wr.level;
  end

  assign prdata = status_rd ? status : '0;  // Zero for any other access.
  assign pready = 1'b1;                     // No wait states.

  // Dropped write, or an address that is not valid for the direction.
  assign pslverr = (data_wr & wr.full) | (access & ~data_wr & ~status_rd);

endmodule

/* rtl/stream_reader.sv */
`timescale 1ns/100ps

module stream_reader
  import cdc_fifo_pkg::*;
(
  input  logic                  rd_clk,
  input  logic                  rd_rst_n,
  fifo_rd_if.consumer           rd,
  output logic                  out_valid,
  output logic [DATA_WIDTH-1:0] out_data,
  input  logic                  out_ready
);

  logic                  pending;     // RAM read in flight.
  logic                  skid_valid;
  logic [DATA_WIDTH-1:0] skid_data;
  logic                  out_free;
  logic [1:0]            held;        // Words that stay after this edge.

  assign out_free = ~out_valid | out_ready;
  assign held     = 2'(out_valid & ~out_ready) + 2'(skid_valid) + 2'(pending);
  assign rd.pop   = ~rd.empty & (held < 2'd2);  // Keep a slot for the word.

  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      pending    <= 1'b0;
      out_valid  <= 1'b0;
      skid_valid <= 1'b0;
    end else begin
      pending <= rd.pop;
      if (out_free) begin
        out_valid  <= skid_valid | pending;
        skid_valid <= skid_valid & pending;
      end else if (pending) begin
        skid_valid <= 1'b1;  // Output stalled.
      end
    end
  end

  // Skid entry drains first to keep order.
  always_ff @(posedge rd_clk) begin
    if (out_free) begin
      if (skid_valid) out_data <= skid_data;
      else if (pending) out_data <= rd.data;
    end
    if (pending & (~out_free | skid_valid)) begin
      skid_data <= rd.data;
    end
  end

endmodule

/* rtl/cdc_fifo_top.sv */
`timescale 1ns/100ps

module cdc_fifo_top
  import cdc_fifo_pkg::*;
(
  input  logic                      wr_clk,
  input  logic                      wr_rst_n,
  input  logic                      rd_clk,
  input  logic                      rd_rst_n,

  // APB slave, wr_clk domain.
  input  logic                      psel,
  input  logic                      penable,
  input  logic                      pwrite,
  input  logic [APB_ADDR_WIDTH-1:0] paddr,
  input  logic [APB_DATA_WIDTH-1:0] pwdata,
  output logic [APB_DATA_WIDTH-1:0] prdata,
  output logic                      pready,
  output logic                      pslverr,

  // Stream out, rd_clk domain.
  output logic                      out_valid,
  output logic [DATA_WIDTH-1:0]     out_data,
  input  logic                      out_ready,
  output logic                      aempty
);

  fifo_wr_if i_wr_if ();
  fifo_rd_if i_rd_if ();

  apb_fifo_writer i_writer (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .wr       (i_wr_if.producer)
  );

  async_fifo i_fifo (
    .wr_clk   (wr_clk),
    .wr_rst_n (wr_rst_n),
    .rd_clk   (rd_clk),
    .rd_rst_n (rd_rst_n),
    .wr       (i_wr_if.buffer),
    .rd       (i_rd_if.buffer)
  );

  stream_reader i_reader (
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .rd        (i_rd_if.consumer),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_ready (out_ready)
  );

  assign aempty = i_rd_if.aempty;

endmodule

/* testbench/cdc_fifo_checker.sv */
`timescale 1ns/100ps

module cdc_fifo_checker
  import cdc_fifo_pkg::*;
(
  input logic                  wr_clk,
  input logic                  wr_rst_n,
  input logic                  rd_clk,
  input logic                  rd_rst_n,
  input logic                  psel,
  input logic                  penable,
  input logic                  pready,
  input logic                  pslverr,
  input logic                  out_valid,
  input logic                  out_ready,
  input logic [DATA_WIDTH-1:0] out_data
);

  // ==============================
  // APB side
  // ==============================
  a_pslverr_in_access: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n) pslverr |-> (psel && penable)
  ) else $error("pslverr high outside an access cycle");

  a_pready_in_access: assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n) (psel && penable) |-> pready
  ) else $error("pready low in an access cycle");

  // Held word while the sink stalls.
  a_out_hold: assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data))
  ) else $error("Stream output changed while stalled");

endmodule

bind cdc_fifo_top cdc_fifo_checker i_checker (
  .wr_clk    (wr_clk),
  .wr_rst_n  (wr_rst_n),
  .rd_clk    (rd_clk),
  .rd_rst_n  (rd_rst_n),
  .psel      (psel),
  .penable   (penable),
  .pready    (pready),
  .pslverr   (pslverr),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .out_data  (out_data)
);

/* testbench/cdc_fifo_tb.sv */
`timescale 1ns/100ps

module cdc_fifo_tb
  import cdc_fifo_pkg::*;
();

  localparam int SEED    = 92259;
  localparam int TIMEOUT = 2000;  // Cycles allowed for any wait.

  logic                      wr_clk, wr_rst_n, rd_clk, rd_rst_n;
  logic                      psel, penable, pwrite, pready, pslverr;
  logic [APB_ADDR_WIDTH-1:0] paddr;
  logic [APB_DATA_WIDTH-1:0] pwdata, prdata, rdata;
  logic                      out_valid, out_ready, aempty, err;
  logic [DATA_WIDTH-1:0]     out_data;
  logic [DATA_WIDTH-1:0]     sb [$];  // Accepted words, oldest first.
  logic [31:0]               data_rng, ready_rng;
  logic                      ready_random, ready_level;
  int                        accepted;

  cdc_fifo_top i_cdc_fifo_top (.*);

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopped at the first error.");
  endtask

  initial begin
    wr_clk = 1'b0;
    forever #4 wr_clk = ~wr_clk;
  end

  initial begin
    rd_clk = 1'b0;
    forever #5.5 rd_clk = ~rd_clk;
  end

  // Stream sink.
  initial begin
    out_ready = 1'b0;
    ready_rng = SEED;
    forever begin
      @(posedge rd_clk);
      #1;
      ready_rng = xorshift32(ready_rng);
      out_ready = ready_random ? ready_rng[7] : ready_level;
    end
  end

  // ==============================
  // Scoreboard
  // ==============================
  always @(posedge rd_clk) begin
    if (rd_rst_n && out_valid && out_ready) begin
      if (sb.size() == 0) begin
        fail_run("Stream transfer with no accepted word left");
      end else begin
        assert (out_data == sb[0])
          else fail_run($sformatf("Mismatch at %0t: stream data %0h, expected %0h",
                                  $time, out_data, sb[0]));
        void'(sb.pop_front());
      end
    end
  end

  task automatic apb_access(input logic write, input logic [APB_ADDR_WIDTH-1:0] addr,
                            input logic [APB_DATA_WIDTH-1:0] wdata);
    int cycles;
    @(posedge wr_clk);
    #1;
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = write;
    paddr   = addr;
    pwdata  = wdata;
    @(posedge wr_clk);
    #1;
    penable = 1'b1;
    cycles  = 0;
    #1;
    while (!pready) begin
      @(posedge wr_clk);
      #1;
      cycles++;
      if (cycles > TIMEOUT) fail_run("APB access never saw pready");
    end
    rdata = prdata;  // Response inside the access cycle.
    err   = pslverr;
    @(posedge wr_clk);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic write_word();
    data_rng = xorshift32(data_rng);
    apb_access(1'b1, REG_DATA, data_rng);
    if (!err) begin
      sb.push_back(data_rng[DATA_WIDTH-1:0]);
      accepted++;
    end
  endtask

  task automatic check_err(input logic expected, input string what);
    assert (err == expected)
      else fail_run($sformatf("Mismatch at %0t: pslverr %0b on %s, expected %0b",
                              $time, err, what, expected));
  endtask

  task automatic check_status(input int level);
    apb_access(1'b0, REG_STATUS, '0);
    assert (!err && int'(rdata[STATUS_LEVEL_LSB +: ADDR_WIDTH+1]) == level
            && rdata[STATUS_FULL_BIT] == (level == FIFO_DEPTH)
            && rdata[STATUS_AFULL_BIT] == (level >= AFULL_LEVEL))
      else fail_run($sformatf("Mismatch at %0t: status %0h, expected level %0d",
                              $time, rdata, level));
  endtask

  task automatic wait_drained();
    int cycles;
    cycles = 0;
    while (sb.size() != 0) begin
      @(posedge rd_clk);
      cycles++;
      if (cycles > TIMEOUT) fail_run("Stream did not drain in time");
    end
  endtask

  task automatic wait_valid();
    int cycles;
    cycles = 0;
    while (!out_valid) begin
      @(posedge rd_clk);
      cycles++;
      if (cycles > TIMEOUT) fail_run("out_valid never rose");
    end
  endtask

  // Lets both pointer synchronizers catch up.
  task automatic settle();
    repeat (8) @(posedge rd_clk);
  endtask

  initial begin
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    wr_rst_n     = 1'b0;
    rd_rst_n     = 1'b0;
    ready_random = 1'b0;
    ready_level  = 1'b0;
    data_rng     = SEED;
    accepted     = 0;
    fork
      begin
        repeat (2) @(posedge wr_clk);
        #1 wr_rst_n = 1'b1;
      end
      begin
        repeat (2) @(posedge rd_clk);
        #1 rd_rst_n = 1'b1;
      end
    join
    assert (!out_valid && aempty) else fail_run("Wrong out_valid or aempty after reset");

    ready_level = 1'b1;  // In-order transfer, stream always ready.
    repeat (40) write_word();
    wait_drained();

    // ==============================
    // Stalled stream, status and back-pressure
    // ==============================
    ready_level = 1'b0;
    repeat (2) begin
      write_word();
      check_err(1'b0, "write with room");
    end
    wait_valid();
    settle();  // Both words now parked in the reader.
    assert (aempty) else fail_run("aempty low with the FIFO emptied into the reader");
    check_status(0);
    for (int n = 1; n <= FIFO_DEPTH; n++) begin
      write_word();
      check_err(1'b0, "write with room");
      check_status(n);
      if (n == 8) begin
        apb_access(1'b1, 4'h8, 32'h5a);
        check_err(1'b1, "write to a bad address");
        apb_access(1'b0, 4'h8, '0);
        check_err(1'b1, "read of a bad address");
        assert (rdata == '0) else fail_run("Bad address read returned nonzero data");
        check_status(8);
      end
    end
    settle();
    assert (!aempty) else fail_run("aempty high with a full FIFO");
    write_word();
    check_err(1'b1, "write to a full FIFO");
    check_status(FIFO_DEPTH);
    ready_level = 1'b1;
    wait_drained();
    settle();
    assert (aempty) else fail_run("aempty low after the stream drained");
    check_status(0);

    // Random ready against a continuous writer.
    ready_random = 1'b1;
    accepted     = 0;
    for (int tries = 0; accepted < 200; tries++) begin
      if (tries > TIMEOUT) begin
        fail_run("Writer could not place 200 words");
      end else begin
        write_word();
      end
    end
    wait_drained();
    settle();

    if (!out_valid && aempty) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      fail_run("Stream still busy after the last accepted word");
    end
  end

endmodule

/* list.f */
rtl/cdc_fifo_pkg.sv
rtl/fifo_ports_if.sv
rtl/dualport_ram.sv
rtl/async_fifo.sv
rtl/apb_fifo_writer.sv
rtl/stream_reader.sv
rtl/cdc_fifo_top.sv
testbench/cdc_fifo_checker.sv
testbench/cdc_fifo_tb.sv

/* Makefile */
SIM  := obj_dir/Vcdc_fifo_tb
SRCS := $(shell cat list.f)

.PHONY: run clean

run: $(SIM)
	-$(SIM) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log

$(SIM): list.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module cdc_fifo_tb -f list.f -o Vcdc_fifo_tb

clean:
	rm -rf obj_dir sim.log
